/* Makefile */
VERILATOR ?= verilator
TOP       ?= harness_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the testbench verdict line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* block_streamer.sv */
`timescale 1ns/100ps

module block_streamer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [link_pkg::class_idx_width-1:0]  class_idx,
    input  logic [link_pkg::num_classes-1:0][mem_map_pkg::rom_addr_width-1:0] cur_addr_all,
    input  logic [link_pkg::bus_width-1:0]        rom_data,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  rom_en,
    output logic [mem_map_pkg::rom_addr_width-1:0] rom_addr,
    output logic [link_pkg::bus_width-1:0]        data_out,
    output logic                                  cs_n,
    output logic                                  oe_req
);
    import link_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_setup,     // first rom read issued
        st_wait,      // rom latency
        st_stream,
        st_release    // bus held one more cycle
    } xfer_state_t;

    xfer_state_t                state;
    logic [class_idx_width-1:0] cls;
    logic [rom_addr_width-1:0]  addr;
    logic [len_width-1:0]       cnt;      // words already driven
    logic [len_width-1:0]       words;
    logic                       word_out;
    logic                       burst_end;

    assign words     = len_width'(read_words[cls]);
    assign word_out  = (state == st_wait) || (state == st_stream && cnt != words);
    assign burst_end = (state == st_stream) && (cnt == words);
    assign busy      = (state != st_idle);
    assign rom_addr  = addr;

    // read one word ahead of the bus, stop after the last one
    assign rom_en = (state == st_setup) || (state == st_wait) ||
                    (state == st_stream && (cnt + len_width'(1)) < words);

    // ============================================================
    // transfer fsm
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (start) state <= st_setup;
                st_setup:   state <= st_wait;
                st_wait:    state <= st_stream;
                st_stream:  if (burst_end) state <= st_release;
                st_release: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // class, rom address and word count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cls  <= '0;
            addr <= '0;
            cnt  <= '0;
        end else if (state == st_idle && start) begin
            cls  <= class_idx;
            addr <= cur_addr_all[class_idx];   // current block of that ring
            cnt  <= '0;
        end else begin
            if (rom_en) addr <= addr + 1'b1;
            if (word_out) cnt <= cnt + 1'b1;
        end
    end

    // ============================================================
    // bus framing
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
            cs_n     <= 1'b1;
            oe_req   <= 1'b1;
            done     <= 1'b0;
        end else begin
            done <= burst_end;
            if (word_out) begin
                data_out <= rom_data;
                cs_n     <= 1'b0;
                oe_req   <= 1'b0;
            end else if (burst_end) begin
                data_out <= '0;
                cs_n     <= 1'b1;   // oe stays low one more cycle
            end else if (state == st_release) begin
                oe_req <= 1'b1;
            end
        end
    end

endmodule

/* chip_reset_seq.sv */
`timescale 1ns/100ps

module chip_reset_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic chip_start,   // one cycle kick
    output logic sw_clk,
    output logic chip_rst_n
);

    typedef enum logic [2:0] {
        st_idle,
        st_clk_off,
        st_rst_low,
        st_rst_high,
        st_clk_on
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;

    // one step per cycle, kicks ignored outside idle
    always_comb begin
        next_state = state;
        case (state)
            st_idle:     if (chip_start) next_state = st_clk_off;
            st_clk_off:  next_state = st_rst_low;
            st_rst_low:  next_state = st_rst_high;
            st_rst_high: next_state = st_clk_on;
            st_clk_on:   next_state = st_idle;
            default:     next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            sw_clk     <= 1'b0;
            chip_rst_n <= 1'b1;
        end else begin
            state <= next_state;
            if (next_state == st_clk_off) sw_clk <= 1'b0;       // gate chip clock first
            if (next_state == st_rst_low) chip_rst_n <= 1'b0;
            if (next_state == st_rst_high) chip_rst_n <= 1'b1;
            if (next_state == st_clk_on) sw_clk <= 1'b1;        // clock back last
        end
    end

endmodule

/* class_pointer.sv */
`timescale 1ns/100ps

module class_pointer #(
    parameter int base   = 0,   // first word of the ring
    parameter int words  = 1,   // words per block
    parameter int blocks = 1    // blocks in the ring
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic                                  sel,
    input  logic                                  done,
    output logic [mem_map_pkg::rom_addr_width-1:0] cur_addr
);
    import mem_map_pkg::*;

    logic active;   // this class owns the running burst
    logic at_last;

    assign at_last = (cur_addr == rom_addr_width'(base + (blocks - 1) * words));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (start) begin
            active <= sel;
        end else if (done) begin
            active <= 1'b0;
        end
    end

    // step to next block once the burst is complete
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_addr <= rom_addr_width'(base);
        end else if (done && active) begin
            cur_addr <= at_last ? rom_addr_width'(base) : cur_addr + rom_addr_width'(words);
        end
    end

endmodule

/* cmd_decoder.sv */
`timescale 1ns/100ps

module cmd_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 config_req,
    input  logic [link_pkg::bus_width-1:0]       data_in,
    input  logic                                 busy,
    output logic                                 start,
    output logic [link_pkg::class_idx_width-1:0] class_idx
);
    import link_pkg::*;

    logic                       req_q;
    logic [code_width-1:0]      code_q;
    logic [class_idx_width:0]   code_entry;
    logic                       code_valid;

    // lookup on the sampled code
    assign code_entry = class_of_code[code_q];
    assign code_valid = code_entry[class_idx_width];

    // ============================================================
    // request sampling
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            code_q <= '0;
        end else begin
            req_q  <= config_req;
            code_q <= data_in[code_lsb +: code_width];  // word valid while req high
        end
    end

    // start only when streamer idle, not back to back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start     <= 1'b0;
            class_idx <= '0;
        end else begin
            start <= req_q && code_valid && !busy && !start;
            if (req_q && code_valid && !busy && !start) begin
                class_idx <= code_entry[class_idx_width-1:0];
            end
        end
    end

endmodule

/* harness_sva.sv */
`timescale 1ns/100ps

module harness_sva (
    input logic clk,
    input logic rst_n,
    input logic cs_n,
    input logic oe_req,
    input logic sw_clk,
    input logic chip_rst_n
);

    // bus owned whenever a word is framed
    bus_owned: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> !oe_req)
        else $error("cs_n low while oe_req high");

    // longest read is four words
    burst_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (!cs_n && !$past(cs_n, 1) && !$past(cs_n, 2) && !$past(cs_n, 3)) |=> cs_n)
        else $error("cs_n low for more than four cycles");

    reset_gated: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(chip_rst_n) |-> !sw_clk)   // chip clock gated first
        else $error("chip_rst_n fell while sw_clk high");

endmodule

bind harness_top harness_sva harness_sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cs_n       (cs_n),
    .oe_req     (oe_req),
    .sw_clk     (sw_clk),
    .chip_rst_n (chip_rst_n)
);

/* harness_tb.sv */
`timescale 1ns/100ps

module harness_tb;
    import link_pkg::*;
    import mem_map_pkg::*;

    localparam int burst_cycles   = 16;   // request to bus release, longest class
    localparam int num_requests   = 3 + 3 + 6 + 4 + 40;
    localparam int timeout_cycles = 16 + num_requests * burst_cycles + 4 * 24 + 2 * 8 + 200;
    localparam int code_of_class [num_classes] = '{
        code_cfg, code_weiaddr, code_flgwei, code_wei, code_flgact, code_act
    };
    localparam int bad_codes [4] = '{1, 2, 9, 15};
    // {sw_clk, chip_rst_n} after each edge of the chip reset sequence
    localparam logic [1:0] reset_steps [6] = '{2'b01, 2'b00, 2'b01, 2'b11, 2'b11, 2'b11};

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 config_req;
    logic [bus_width-1:0] data_in;
    logic                 chip_start;
    logic [bus_width-1:0] data_out;
    logic                 cs_n;
    logic                 oe_req;
    logic                 sw_clk;
    logic                 chip_rst_n;

    logic [bus_width-1:0] rom_model [rom_depth];
    int                   read_count [num_classes];   // completed reads per class
    int                   num_checks = 0;
    int                   num_errors = 0;
    logic [31:0]          lcg_state = 32'hbe99d5d8;

    always #5 clk = ~clk;

    harness_top harness_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .chip_start (chip_start),
        .data_out   (data_out),
        .cs_n       (cs_n),
        .oe_req     (oe_req),
        .sw_clk     (sw_clk),
        .chip_rst_n (chip_rst_n)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare(input string name, input logic [bus_width-1:0] got,
                           input logic [bus_width-1:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // ============================================================
    // chip side read, held until cs_n is seen low
    // ============================================================
    task automatic read_block(input int c);
        logic [bus_width-1:0] cmd;
        int k;
        int addr;
        cmd = {next_rand(), next_rand(), next_rand(), next_rand()};
        cmd[code_lsb +: code_width] = code_width'(code_of_class[c]);
        k = 0;
        @(posedge clk);
        config_req <= 1'b1;
        data_in    <= cmd;
        repeat (burst_cycles) begin
            @(negedge clk);
            if (!cs_n) break;
        end
        if (cs_n) begin
            num_errors++;
            $display("no burst for class %0d within %0d cycles", c, burst_cycles);
            @(posedge clk);
            config_req <= 1'b0;
        end else begin
            while (!cs_n && k < 8) begin
                addr = base_addr[c] + (read_count[c] % num_blocks[c]) * read_words[c] + k;
                if (k < read_words[c]) begin
                    compare("data_out", data_out, rom_model[addr[rom_addr_width-1:0]]);
                end
                compare("oe_req", bus_width'(oe_req), '0);
                k++;
                @(posedge clk);
                config_req <= 1'b0;
                @(negedge clk);
            end
            compare("cs_n low cycles", bus_width'(k), bus_width'(read_words[c]));
            compare("oe_req", bus_width'(oe_req), '0);   // held past the burst
            @(negedge clk);
            compare("oe_req", bus_width'(oe_req), bus_width'(1'b1));
            read_count[c]++;
        end
    endtask

    task automatic check_reset_values();
        @(negedge clk);
        compare("cs_n", bus_width'(cs_n), bus_width'(1'b1));
        compare("oe_req", bus_width'(oe_req), bus_width'(1'b1));
        compare("sw_clk", bus_width'(sw_clk), '0);
        compare("chip_rst_n", bus_width'(chip_rst_n), bus_width'(1'b1));
        compare("data_out", data_out, '0);
    endtask

    task automatic reject_invalid_codes();
        logic [bus_width-1:0] cmd;
        for (int i = 0; i < 4; i++) begin
            cmd = {next_rand(), next_rand(), next_rand(), next_rand()};
            cmd[code_lsb +: code_width] = code_width'(bad_codes[i]);
            @(posedge clk);
            config_req <= 1'b1;
            data_in    <= cmd;
            repeat (20) begin
                @(negedge clk);
                compare("cs_n", bus_width'(cs_n), bus_width'(1'b1));
            end
            @(posedge clk);
            config_req <= 1'b0;
            read_block(int'((next_rand() >> 8) % 32'(num_classes)));
        end
    endtask

    // extra_kick lands while the sequence is running
    task automatic run_chip_reset(input logic extra_kick);
        @(posedge clk);
        chip_start <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            chip_start <= (i == 0) ? extra_kick : 1'b0;
            @(negedge clk);
            compare("sw_clk", bus_width'(sw_clk), bus_width'(reset_steps[i][1]));
            compare("chip_rst_n", bus_width'(chip_rst_n), bus_width'(reset_steps[i][0]));
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        rst_n      <= 1'b0;
        config_req <= 1'b0;
        data_in    <= '0;
        chip_start <= 1'b0;
        foreach (read_count[i]) read_count[i] = 0;
        $readmemh(rom_file, rom_model);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_values();
        repeat (3) read_block(3);   // two block ring, blocks 0 1 0
        repeat (3) read_block(0);   // single block config ring
        for (int c = 0; c < num_classes; c++) read_block(c);
        reject_invalid_codes();
        run_chip_reset(1'b0);
        run_chip_reset(1'b1);
        repeat (40) read_block(int'((next_rand() >> 8) % 32'(num_classes)));
        repeat (4) @(posedge clk);
        $display("%0d checks, %0d errors", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* harness_top.sv */
`timescale 1ns/100ps

module harness_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            config_req,
    input  logic [link_pkg::bus_width-1:0]  data_in,
    input  logic                            chip_start,
    output logic [link_pkg::bus_width-1:0]  data_out,
    output logic                            cs_n,
    output logic                            oe_req,
    output logic                            sw_clk,
    output logic                            chip_rst_n
);
    import link_pkg::*;
    import mem_map_pkg::*;

    logic                                          start;
    logic                                          busy;
    logic                                          done;
    logic [class_idx_width-1:0]                    class_idx;
    logic [num_classes-1:0][rom_addr_width-1:0]    cur_addr_all;
    logic                                          rom_en;
    logic [rom_addr_width-1:0]                     rom_addr;
    logic [bus_width-1:0]                          rom_data;

    chip_reset_seq chip_reset_seq_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .chip_start (chip_start),
        .sw_clk     (sw_clk),
        .chip_rst_n (chip_rst_n)
    );

    cmd_decoder cmd_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .busy       (busy),
        .start      (start),
        .class_idx  (class_idx)
    );

    // ============================================================
    // one ring pointer per read class
    // ============================================================
    for (genvar i = 0; i < num_classes; i++) begin : g_ptr
        class_pointer #(
            .base   (base_addr[i]),
            .words  (read_words[i]),
            .blocks (num_blocks[i])
        ) class_pointer_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start),
            .sel      (class_idx == class_idx_width'(i)),
            .done     (done),
            .cur_addr (cur_addr_all[i])
        );
    end

    block_streamer block_streamer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .class_idx    (class_idx),
        .cur_addr_all (cur_addr_all),
        .rom_data     (rom_data),
        .busy         (busy),
        .done         (done),
        .rom_en       (rom_en),
        .rom_addr     (rom_addr),
        .data_out     (data_out),
        .cs_n         (cs_n),
        .oe_req       (oe_req)
    );

    word_rom word_rom_i (
        .clk      (clk),
        .rom_en   (rom_en),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

endmodule

/* link_pkg.sv */
package link_pkg;

    // ============================================================
    // chip link bus and command word
    // ============================================================
    localparam int bus_width       = 128;
    localparam int code_lsb        = 18;   // ifcode at [21:18]
    localparam int code_width      = 4;
    localparam int num_classes     = 6;
    localparam int class_idx_width = 3;

    // interface codes driven by the chip
    localparam int code_cfg     = 0;
    localparam int code_weiaddr = 3;
    localparam int code_flgwei  = 5;
    localparam int code_wei     = 4;
    localparam int code_flgact  = 7;
    localparam int code_act     = 6;

    // ============================================================
    // code to class lookup, msb is the valid bit
    // classes in order cfg, weiaddr, flgwei, wei, flgact, act
    // ============================================================
    localparam logic [class_idx_width:0] class_of_code [2**code_width] = '{
        code_cfg:     {1'b1, 3'd0},
        code_weiaddr: {1'b1, 3'd1},
        code_flgwei:  {1'b1, 3'd2},
        code_wei:     {1'b1, 3'd3},
        code_flgact:  {1'b1, 3'd4},
        code_act:     {1'b1, 3'd5},
        default:      '0           // write codes and spares
    };

endpackage

/* mem_map_pkg.sv */
package mem_map_pkg;

    // ============================================================
    // rom geometry
    // ============================================================
    localparam int    rom_depth      = 32;
    localparam int    rom_addr_width = 5;
    localparam string rom_file       = "rom_init.hex";

    // word count width, holds the largest read_words entry
    localparam int len_width = 3;

    // ============================================================
    // per class memory map, indexed by class
    // cfg, weiaddr, flgwei, wei, flgact, act
    // ============================================================

    // words streamed per read
    localparam int read_words [link_pkg::num_classes] = '{
        2, 2, 2, 4, 2, 4
    };

    // blocks in each ring before wrapping
    localparam int num_blocks [link_pkg::num_classes] = '{
        1, 2, 2, 2, 2, 2
    };

    // first word of each ring
    // rings laid end to end, words 0..29 used
    localparam int base_addr [link_pkg::num_classes] = '{
        0, 2, 6, 10, 18, 22
    };

endpackage

/* rom_init.hex */
// 128-bit rom words, one per line, address 0 to 31 in order
5a00a5ff3c00c3ff0f00f0ff960069ff
5a01a5fe3c01c3fe0f01f0fe960169fe
5a02a5fd3c02c3fd0f02f0fd960269fd
5a03a5fc3c03c3fc0f03f0fc960369fc
5a04a5fb3c04c3fb0f04f0fb960469fb
5a05a5fa3c05c3fa0f05f0fa960569fa
5a06a5f93c06c3f90f06f0f9960669f9
5a07a5f83c07c3f80f07f0f8960769f8
5a08a5f73c08c3f70f08f0f7960869f7
5a09a5f63c09c3f60f09f0f6960969f6
5a0aa5f53c0ac3f50f0af0f5960a69f5
5a0ba5f43c0bc3f40f0bf0f4960b69f4
5a0ca5f33c0cc3f30f0cf0f3960c69f3
5a0da5f23c0dc3f20f0df0f2960d69f2
5a0ea5f13c0ec3f10f0ef0f1960e69f1
5a0fa5f03c0fc3f00f0ff0f0960f69f0
5a10a5ef3c10c3ef0f10f0ef961069ef
5a11a5ee3c11c3ee0f11f0ee961169ee
5a12a5ed3c12c3ed0f12f0ed961269ed
5a13a5ec3c13c3ec0f13f0ec961369ec
5a14a5eb3c14c3eb0f14f0eb961469eb
5a15a5ea3c15c3ea0f15f0ea961569ea
5a16a5e93c16c3e90f16f0e9961669e9
5a17a5e83c17c3e80f17f0e8961769e8
5a18a5e73c18c3e70f18f0e7961869e7
5a19a5e63c19c3e60f19f0e6961969e6
5a1aa5e53c1ac3e50f1af0e5961a69e5
5a1ba5e43c1bc3e40f1bf0e4961b69e4
5a1ca5e33c1cc3e30f1cf0e3961c69e3
5a1da5e23c1dc3e20f1df0e2961d69e2
5a1ea5e13c1ec3e10f1ef0e1961e69e1
5a1fa5e03c1fc3e00f1ff0e0961f69e0

/* src.f */
link_pkg.sv
mem_map_pkg.sv
chip_reset_seq.sv
cmd_decoder.sv
class_pointer.sv
block_streamer.sv
word_rom.sv
harness_top.sv
harness_sva.sv
harness_tb.sv

/* word_rom.sv */
`timescale 1ns/100ps

module word_rom (
    input  logic                                  clk,
    input  logic                                  rom_en,
    input  logic [mem_map_pkg::rom_addr_width-1:0] rom_addr,
    output logic [link_pkg::bus_width-1:0]        rom_data
);
    import link_pkg::*;
    import mem_map_pkg::*;

    logic [bus_width-1:0] mem [rom_depth];

    initial $readmemh(rom_file, mem);

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rom_en) rom_data <= mem[rom_addr];
    end

endmodule
